// File: source/rhythm_pkg.sv
package rhythm_pkg;

    localparam int LANES      = 4;
    localparam int ROWS       = 16;
    localparam int FRAME_W    = 16;  // frame is FRAME_W x FRAME_W leds
    localparam int SCORE_W    = 7;
    localparam int MISS_LIMIT = 3;
    localparam int PERIOD_W   = 16;

    typedef logic [LANES-1:0] lane_t;     // one bit per lane
    typedef lane_t [ROWS-1:0] board_t;    // board[0] is the top row
    typedef logic [FRAME_W*FRAME_W-1:0] frame_t;

    // status byte, top bit first
    typedef struct packed {
        logic [2:0] reserved;  // always 3'b111
        logic       paused;
        logic [1:0] chart;
        logic       alive;
        logic       no_hit;
    } report_fields_t;

    typedef union packed {
        logic [7:0]     raw;
        report_fields_t fields;
    } host_report_t;

    // "good game" picture, word w sits at bits 16w+15:16w
    localparam frame_t GAME_OVER_IMAGE = {
        16'b0111_1110_0101_0100,  // word 15
        16'b0000_1010_0111_1100,
        16'b0000_1110_0000_0000,
        16'b0000_0000_0111_1000,  // d top, e bottom
        16'b0011_1100_0100_0000,
        16'b0010_0100_0010_0000,
        16'b0011_1100_0100_0000,
        16'b0000_0000_0111_1000,  // o top, m bottom
        16'b0000_0000_0000_0000,
        16'b0011_1100_0111_1100,
        16'b0010_0100_0100_1000,
        16'b0011_1100_0111_1000,  // o top, a bottom
        16'b0000_0000_0000_0000,
        16'b0111_1110_0111_1110,
        16'b0101_0010_0101_0010,
        16'b0111_0110_0111_0110   // word 0, g top and bottom
    };

endpackage

// File: source/refresh_timer.sv
`timescale 1ns/1ps

module refresh_timer (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [rhythm_pkg::PERIOD_W-1:0] period,
    output logic                          tick
);
    import rhythm_pkg::*;

    logic [PERIOD_W-1:0] cnt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (cnt >= period) begin
            cnt <= '0;  // wrap after reaching period
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    // one cycle before the wrap
    assign tick = (cnt == period - 1'b1);

    // shorter periods would put the tick on the wrap cycle or never raise it
    a_period_min: assert property (
        @(posedge clk) disable iff (!rst_n)
        period >= PERIOD_W'(2)
    );

endmodule

// File: source/note_field.sv
`timescale 1ns/1ps

module note_field (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          tick,
    input  logic                          paused,
    input  rhythm_pkg::lane_t             key_hit,
    input  rhythm_pkg::lane_t             chart_row,
    output rhythm_pkg::board_t            board,
    output logic [rhythm_pkg::SCORE_W-1:0] score,
    output logic                          game_over
);
    import rhythm_pkg::*;

    localparam int MISS_W = $clog2(MISS_LIMIT);

    logic [MISS_W-1:0] miss_cnt;
    lane_t             bottom;
    lane_t             hit_lanes;
    lane_t             miss_lanes;
    logic              step;       // a tick that counts
    logic              any_hit;
    logic              any_miss;
    logic              last_miss;  // this miss ends the game

    assign bottom     = board[ROWS-1];
    assign hit_lanes  = bottom & key_hit;
    assign miss_lanes = bottom & ~key_hit;
    assign any_hit    = |hit_lanes;
    assign any_miss   = |miss_lanes;

    assign step      = tick && !paused && !game_over;
    assign last_miss = any_miss && (miss_cnt == MISS_W'(MISS_LIMIT - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            score <= '0;
        end else if (step && any_hit) begin
            score <= score + 1'b1;  // one point per tick, wraps
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            miss_cnt  <= '0;
            game_over <= 1'b0;
        end else if (step && any_miss) begin
            miss_cnt <= miss_cnt + 1'b1;
            if (last_miss) begin
                game_over <= 1'b1;
            end
        end
    end

    // everything falls one row, the bottom row leaves, hit or not
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            board <= '0;
        end else if (step && !last_miss) begin
            board <= {board[ROWS-2:0], chart_row};
        end
    end

    a_board_only_on_tick: assert property (
        @(posedge clk) disable iff (!rst_n)
        !tick |=> $stable(board)
    );

    a_game_over_sticky: assert property (
        @(posedge clk) disable iff (!rst_n)
        game_over |=> game_over
    );

endmodule

// File: source/frame_render.sv
`timescale 1ns/1ps

module frame_render (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               tick,
    input  logic               game_over,
    input  rhythm_pkg::board_t board,
    output rhythm_pkg::frame_t frame
);
    import rhythm_pkg::*;

    localparam int LANE_WORDS = FRAME_W / LANES;  // 3 lit + 1 blank

    frame_t lane_img;

    // word 4c..4c+2 carry lane c, row 0 lands in bit 15
    always_comb begin
        lane_img = '0;
        for (int c = 0; c < LANES; c++) begin
            for (int k = 0; k < LANE_WORDS - 1; k++) begin
                for (int r = 0; r < ROWS; r++) begin
                    lane_img[(c*LANE_WORDS + k)*FRAME_W + (FRAME_W - 1 - r)] = board[r][c];
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            frame <= '0;
        end else if (game_over) begin
            frame <= GAME_OVER_IMAGE;
        end else if (tick) begin
            frame <= lane_img;  // board before this tick's shift
        end
    end

endmodule

// File: source/host_report.sv
`timescale 1ns/1ps

module host_report (
    input  logic                     clk,
    input  logic                     rst_n,
    input  rhythm_pkg::lane_t        key_hit,
    input  rhythm_pkg::lane_t        bottom,
    input  logic                     paused,
    input  logic [1:0]               chart_select,
    output rhythm_pkg::host_report_t report,
    output logic                     report_valid
);
    import rhythm_pkg::*;

    host_report_t prev;

    always_comb begin
        report.fields.reserved = 3'b111;
        report.fields.paused   = paused;
        report.fields.chart    = chart_select;
        report.fields.alive    = rst_n;
        report.fields.no_hit   = ~|(key_hit & bottom);
    end

    // last byte seen by the host
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prev.raw <= 8'h00;
        end else begin
            prev <= report;
        end
    end

    assign report_valid = (report.raw != prev.raw);

endmodule

// File: source/rhythm_top.sv
`timescale 1ns/1ps

module rhythm_top (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [rhythm_pkg::PERIOD_W-1:0]   refresh_period,
    input  logic                              paused,
    input  logic [rhythm_pkg::LANES-1:0]      key_hit,
    input  logic [rhythm_pkg::LANES-1:0]      chart_row,
    input  logic [1:0]                        chart_select,
    output logic [rhythm_pkg::FRAME_W*rhythm_pkg::FRAME_W-1:0] frame_flat,
    output logic [rhythm_pkg::SCORE_W-1:0]    score,
    output logic [7:0]                        report,
    output logic                              report_valid
);
    import rhythm_pkg::*;

    logic   tick;
    logic   game_over;
    board_t board;

    refresh_timer i_refresh_timer (
        .clk    (clk),
        .rst_n  (rst_n),
        .period (refresh_period),
        .tick   (tick)
    );

    note_field i_note_field (
        .clk       (clk),
        .rst_n     (rst_n),
        .tick      (tick),
        .paused    (paused),
        .key_hit   (key_hit),
        .chart_row (chart_row),
        .board     (board),
        .score     (score),
        .game_over (game_over)
    );

    frame_render i_frame_render (
        .clk       (clk),
        .rst_n     (rst_n),
        .tick      (tick),
        .game_over (game_over),
        .board     (board),
        .frame     (frame_flat)
    );

    host_report i_host_report (
        .clk          (clk),
        .rst_n        (rst_n),
        .key_hit      (key_hit),
        .bottom       (board[ROWS-1]),  // row under the keys
        .paused       (paused),
        .chart_select (chart_select),
        .report       (report),
        .report_valid (report_valid)
    );

endmodule

// File: tests/rhythm_model.svh
`ifndef RHYTHM_MODEL_SVH
`define RHYTHM_MODEL_SVH

// cycle model of the playfield, one call to model_step per rising edge
logic [PERIOD_W-1:0] m_cnt;
lane_t               m_rows [ROWS];  // m_rows[0] is the top row
logic [SCORE_W-1:0]  m_score;
int                  m_misses;
logic                m_over;
frame_t              m_frame;
host_report_t        m_prev;          // byte the host saw last cycle

task automatic model_reset();
    m_cnt    = '0;
    m_score  = '0;
    m_misses = 0;
    m_over   = 1'b0;
    m_frame  = '0;
    m_prev   = '0;
    for (int r = 0; r < ROWS; r++) begin
        m_rows[r] = '0;
    end
endtask

// lanes as three lit columns and a gap, top row in the msb
function automatic frame_t draw_lanes();
    frame_t img;
    int     lane;
    img = '0;
    for (int w = 0; w < FRAME_W; w++) begin
        lane = w / 4;
        if (w % 4 != 3) begin
            for (int b = 0; b < FRAME_W; b++) begin
                img[FRAME_W*w + b] = m_rows[ROWS-1-b][lane];
            end
        end
    end
    return img;
endfunction

function automatic host_report_t expected_report();
    host_report_t r;
    logic         no_hit;
    no_hit = ((key_hit & m_rows[ROWS-1]) == '0);
    r.raw  = {3'b111, paused, chart_select, rst_n, no_hit};
    return r;
endfunction

task automatic model_step();
    logic  tick_now;
    logic  counts;
    lane_t bottom;
    bottom   = m_rows[ROWS-1];
    tick_now = (m_cnt == refresh_period - 1);
    m_prev   = expected_report();
    if (m_over) begin
        m_frame = GAME_OVER_IMAGE;
    end else if (tick_now) begin
        m_frame = draw_lanes();  // board before the shift
    end
    counts = tick_now && !paused && !m_over;
    if (counts) begin
        if ((bottom & key_hit) != '0) begin
            m_score = m_score + 1'b1;
        end
        if ((bottom & ~key_hit) != '0) begin
            m_misses++;
            if (m_misses == MISS_LIMIT) begin
                m_over = 1'b1;
            end
        end
        if (!m_over) begin
            for (int r = ROWS - 1; r > 0; r--) begin
                m_rows[r] = m_rows[r-1];
            end
            m_rows[0] = chart_row;
        end
    end
    if (m_cnt >= refresh_period) begin
        m_cnt = '0;
    end else begin
        m_cnt = m_cnt + 1'b1;
    end
endtask

`endif

// File: tests/rhythm_tb.sv
`timescale 1ns/1ps

module rhythm_tb;
    import rhythm_pkg::*;

    localparam int CLK_NS       = 20;
    localparam int NUM_GAMES    = 6;
    localparam int GAME_CYCLES  = 8000;  // cap on one game
    localparam int RESET_CYCLES = 16;
    localparam int COOL_CYCLES  = 24;    // idle after game over
    localparam int RUN_CYCLES   = NUM_GAMES * (RESET_CYCLES + 1 + GAME_CYCLES + COOL_CYCLES);

    logic                clk;
    logic                rst_n;
    logic [PERIOD_W-1:0] refresh_period;
    logic                paused;
    lane_t               key_hit;
    lane_t               chart_row;
    logic [1:0]          chart_select;
    frame_t              frame_flat;
    logic [SCORE_W-1:0]  score;
    host_report_t        report;
    logic                report_valid;

    integer seed;
    int     pause_left;
    int     miss_odds;   // one random key pattern in miss_odds cycles
    int     games_ended;

    `include "rhythm_model.svh"

    rhythm_top i_rhythm_top (
        .clk            (clk),
        .rst_n          (rst_n),
        .refresh_period (refresh_period),
        .paused         (paused),
        .key_hit        (key_hit),
        .chart_row      (chart_row),
        .chart_select   (chart_select),
        .frame_flat     (frame_flat),
        .score          (score),
        .report         (report),
        .report_valid   (report_valid)
    );

    always #(CLK_NS / 2) clk = ~clk;

    task automatic check_frame(frame_t exp_f, frame_t act_f);
        if (act_f !== exp_f) begin
            $display("** Error @%0t: frame_flat expected %h got %h", $time, exp_f, act_f);
            $display("TEST FAILED");
            $fatal(1, "frame mismatch");
        end
    endtask

    task automatic check_score(logic [SCORE_W-1:0] exp_s, logic [SCORE_W-1:0] act_s);
        if (act_s !== exp_s) begin
            $display("** Error @%0t: score expected %0d got %0d", $time, exp_s, act_s);
            $display("TEST FAILED");
            $fatal(1, "score mismatch");
        end
    endtask

    task automatic check_report(host_report_t exp_r, logic exp_v,
                                host_report_t act_r, logic act_v);
        if (act_r.raw !== exp_r.raw) begin
            $display("** Error @%0t: report expected %h got %h", $time, exp_r.raw, act_r.raw);
            $display("TEST FAILED");
            $fatal(1, "report mismatch");
        end else if (act_v !== exp_v) begin
            $display("** Error @%0t: report_valid expected %b got %b", $time, exp_v, act_v);
            $display("TEST FAILED");
            $fatal(1, "report_valid mismatch");
        end
    endtask

    task automatic step_edge();
        @(posedge clk);
        if (rst_n === 1'b1) begin
            model_step();  // sees the inputs the DUT sampled
        end
    endtask

    task automatic compare_outputs();
        host_report_t exp_r;
        @(negedge clk);
        exp_r = expected_report();
        check_frame(m_frame, frame_flat);
        check_score(m_score, score);
        check_report(exp_r, exp_r.raw != m_prev.raw, report, report_valid);
    endtask

    task automatic drive_inputs();
        int r;
        chart_row    <= lane_t'($random(seed));
        chart_select <= 2'($random(seed));
        r = $unsigned($random(seed)) % miss_odds;
        if (r == 0) begin
            key_hit <= lane_t'($random(seed));
        end else begin
            key_hit <= m_rows[ROWS-1];  // player follows the chart
        end
        if (pause_left > 0) begin
            pause_left--;
            paused <= 1'b1;
        end else if ($unsigned($random(seed)) % 96 == 0) begin
            pause_left = (2 + $unsigned($random(seed)) % 4) * (refresh_period + 1);
            paused <= 1'b1;
        end else begin
            paused <= 1'b0;
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        if (rst_n === 1'b1) begin
            model_step();
        end
        rst_n   <= 1'b0;
        paused  <= 1'b0;
        key_hit <= '0;
        pause_left = 0;
        model_reset();
        compare_outputs();
        repeat (RESET_CYCLES - 1) begin
            step_edge();
            compare_outputs();
        end
        step_edge();
        rst_n <= 1'b1;
        compare_outputs();
    endtask

    task automatic play_game();
        int cyc;
        cyc = 0;
        while (!m_over && cyc < GAME_CYCLES) begin
            step_edge();
            drive_inputs();
            compare_outputs();
            cyc++;
        end
        if (m_over) begin
            games_ended++;
        end
        repeat (COOL_CYCLES) begin  // frozen score, fixed image
            step_edge();
            drive_inputs();
            compare_outputs();
        end
    endtask

    initial begin
        seed           = 32'hf42;
        clk            = 1'b0;
        rst_n          = 1'b0;
        paused         = 1'b0;
        key_hit        = '0;
        chart_row      = '0;
        chart_select   = '0;
        refresh_period = PERIOD_W'(3 + $unsigned($random(seed)) % 4);
        pause_left     = 0;
        games_ended    = 0;
        miss_odds      = 6;
        model_reset();
        for (int g = 0; g < NUM_GAMES; g++) begin
            miss_odds = (g % 3 == 0) ? 128 : 6;  // long games wrap the score
            apply_reset();
            play_game();
        end
        if (games_ended == 0) begin
            $display("TEST FAILED");
            $fatal(1, "no game reached game over");
        end else begin
            $display("TEST OK");
            $finish;
        end
    end

    initial begin
        #(RUN_CYCLES * CLK_NS + 5000);
        $display("TEST FAILED");
        $fatal(1, "timeout, run did not finish within its cycle budget");
    end

endmodule

// File: rhythm.f
+incdir+tests
source/rhythm_pkg.sv
source/refresh_timer.sv
source/note_field.sv
source/frame_render.sv
source/host_report.sv
source/rhythm_top.sv
tests/rhythm_tb.sv

// File: Makefile
# Verilator flow for the rhythm playfield engine

VERILATOR  ?= verilator
FILELIST   ?= rhythm.f
TB_TOP     ?= rhythm_tb
RTL_TOP    ?= rhythm_top
BUILD_DIR  ?= obj_dir
LINT_FLAGS ?= -Wall
SIM_FLAGS  ?= --binary --timing --assert
SIM_ARGS   ?=

SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

$(BUILD_DIR)/V$(TB_TOP): $(FILELIST) $(SOURCES) tests/rhythm_model.svh
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		--Mdir $(BUILD_DIR) -o V$(TB_TOP)

sim: $(BUILD_DIR)/V$(TB_TOP)
	./$(BUILD_DIR)/V$(TB_TOP) $(SIM_ARGS)

clean:
	rm -rf $(BUILD_DIR)
